// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - common/bus_pkg.sv
  - common/fetch_pkg.sv
  - source/fetch_hazard.sv
  - fetch/pc_select.sv
  - fetch/fetch_buffer.sv
  - fetch/fetch_frontend.sv
  - target: test
    files:
      - testbench/fetch_properties.sv
      - testbench/tb_fetch_frontend.sv

// File: common/bus_pkg.sv
package bus_pkg;

    // instruction bus types
    // one request carries one byte address
    // one response carries one 64-bit line

    // byte address
    // low two bits zero for a legal instruction address
    // bit 2 selects the word inside a line
    typedef logic [31:0] addr_t;

    // single instruction word
    typedef logic [31:0] word_t;

    // fetch line of two instruction words
    // lower address word sits in [31:0]
    // upper address word sits in [63:32]
    typedef logic [63:0] line_t;

endpackage

// File: common/fetch_pkg.sv
package fetch_pkg;

    // fetch side types
    // shared by the fetch FSM and the PC logic

    // fetch step, one line per request
    localparam bus_pkg::addr_t LINE_BYTES = 32'd8;

    // credits toward the packet consumer
    // 4 bits, so at most 15 credits
    typedef logic [3:0] credit_t;

    // fetch FSM states
    typedef enum logic [1:0] {
        // a request may be presented
        FETCH_REQ   = 2'd0,
        // one request outstanding
        FETCH_WAIT  = 2'd1,
        // one request outstanding, its response is dropped
        FETCH_DRAIN = 2'd2
    } fetch_state_t;

endpackage

// File: fetch/fetch_buffer.sv
`timescale 1ns/1ns

module fetch_buffer (
    input  logic           clk,
    input  logic           reset,
    input  bus_pkg::addr_t pc,
    input  logic           fire,
    input  logic           addr_error,
    input  logic           line_ok,
    input  logic           discard,
    input  bus_pkg::line_t iresp_data,
    output logic           pkt_valid,
    output bus_pkg::addr_t pkt_pc,
    output bus_pkg::word_t pkt_instr0,
    output bus_pkg::word_t pkt_instr1,
    output logic           pkt_slot1_valid,
    output logic           pkt_addr_error
);

    // pc of the outstanding request
    bus_pkg::addr_t req_pc;

    // the two words of the returned line
    bus_pkg::word_t word_lo;
    bus_pkg::word_t word_hi;

    // response that becomes a packet
    logic line_keep;

    assign word_lo   = iresp_data[31:0];
    assign word_hi   = iresp_data[63:32];
    assign line_keep = line_ok & ~discard;

    // capture the request pc when it is consumed
    // the pc register has moved on by the time the line returns
    always_ff @(posedge clk) begin
        if (fire) begin
            req_pc <= pc;
        end
    end

    // packet qualifiers
    always_ff @(posedge clk) begin
        if (reset) begin
            pkt_valid       <= 1'b0;
            pkt_slot1_valid <= 1'b0;
            pkt_addr_error  <= 1'b0;
        end else begin
            // one packet per kept line or per misaligned pc
            pkt_valid       <= line_keep | addr_error;
            // second slot only for an 8-byte aligned pc
            pkt_slot1_valid <= line_keep & ~req_pc[2];
            pkt_addr_error  <= addr_error;
        end
    end

    // packet payload
    always_ff @(posedge clk) begin
        if (addr_error) begin
            // misaligned pc carries no instructions
            pkt_pc     <= pc;
            pkt_instr0 <= '0;
            pkt_instr1 <= '0;
        end else if (line_keep) begin
            pkt_pc <= req_pc;
            if (req_pc[2]) begin
                // odd word, only the upper half belongs to this pc
                pkt_instr0 <= word_hi;
                pkt_instr1 <= '0;
            end else begin
                pkt_instr0 <= word_lo;
                pkt_instr1 <= word_hi;
            end
        end else if (line_ok) begin
            // stale line leaves no words behind
            pkt_instr0 <= '0;
            pkt_instr1 <= '0;
        end
    end

endmodule

// File: fetch/fetch_frontend.sv
`timescale 1ns/1ns

module fetch_frontend #(
    parameter int unsigned    credits      = 4,
    parameter bus_pkg::addr_t reset_vector = 32'hbfc0_0000
) (
    input  logic           clk,
    input  logic           reset,

    // instruction bus
    output logic           ireq_valid,
    output bus_pkg::addr_t ireq_addr,
    input  logic           ireq_addr_ok,
    input  logic           iresp_data_ok,
    input  bus_pkg::line_t iresp_data,

    // redirects
    input  logic           exc_valid,
    input  bus_pkg::addr_t exc_target,
    input  logic           branch_valid,
    input  bus_pkg::addr_t branch_target,

    // packets toward the consumer
    output logic           pkt_valid,
    output bus_pkg::addr_t pkt_pc,
    output bus_pkg::word_t pkt_instr0,
    output bus_pkg::word_t pkt_instr1,
    output logic           pkt_slot1_valid,
    output logic           pkt_addr_error,

    // one pulse per freed packet slot
    input  logic           credit_return
);

    // current fetch pc
    bus_pkg::addr_t pc;

    // fetch control between the blocks
    logic stall;
    logic fire;
    logic discard;
    logic addr_error;
    logic line_ok;

    // the pc is the bus address
    assign ireq_addr = pc;

    pc_select #(
        .reset_vector (reset_vector)
    ) i_pc_select (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .fire          (fire),
        .exc_valid     (exc_valid),
        .exc_target    (exc_target),
        .branch_valid  (branch_valid),
        .branch_target (branch_target),
        .pc            (pc)
    );

    fetch_hazard #(
        .credits (credits)
    ) i_fetch_hazard (
        .clk           (clk),
        .reset         (reset),
        .pc            (pc),
        .ireq_addr_ok  (ireq_addr_ok),
        .iresp_data_ok (iresp_data_ok),
        .credit_return (credit_return),
        .exc_valid     (exc_valid),
        .branch_valid  (branch_valid),
        .ireq_valid    (ireq_valid),
        .stall         (stall),
        .fire          (fire),
        .discard       (discard),
        .addr_error    (addr_error),
        .line_ok       (line_ok)
    );

    fetch_buffer i_fetch_buffer (
        .clk             (clk),
        .reset           (reset),
        .pc              (pc),
        .fire            (fire),
        .addr_error      (addr_error),
        .line_ok         (line_ok),
        .discard         (discard),
        .iresp_data      (iresp_data),
        .pkt_valid       (pkt_valid),
        .pkt_pc          (pkt_pc),
        .pkt_instr0      (pkt_instr0),
        .pkt_instr1      (pkt_instr1),
        .pkt_slot1_valid (pkt_slot1_valid),
        .pkt_addr_error  (pkt_addr_error)
    );

endmodule

// File: fetch/pc_select.sv
`timescale 1ns/1ns

module pc_select #(
    parameter bus_pkg::addr_t reset_vector = 32'hbfc0_0000
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           stall,
    input  logic           fire,
    input  logic           exc_valid,
    input  bus_pkg::addr_t exc_target,
    input  logic           branch_valid,
    input  bus_pkg::addr_t branch_target,
    output bus_pkg::addr_t pc
);

    // redirects held while the pc sits on the bus
    bus_pkg::addr_t exc_hold;
    bus_pkg::addr_t branch_hold;
    logic           exc_saved;
    logic           branch_saved;

    // next pc candidates
    bus_pkg::addr_t pc_seq;
    bus_pkg::addr_t pc_next;
    logic           redirect;
    logic           pc_load;

    assign redirect = exc_valid | branch_valid;

    // sequential fetch
    // round down to the line, then one line further
    // an odd-word pc also lands on the next line
    assign pc_seq = {pc[31:3], 3'b000} + fetch_pkg::LINE_BYTES;

    // saved flags
    // set while stalled, cleared once the pc moves again
    always_ff @(posedge clk) begin
        if (reset) begin
            exc_saved    <= 1'b0;
            branch_saved <= 1'b0;
        end else if (stall) begin
            if (exc_valid) begin
                exc_saved <= 1'b1;
            end
            if (branch_valid) begin
                branch_saved <= 1'b1;
            end
        end else begin
            exc_saved    <= 1'b0;
            branch_saved <= 1'b0;
        end
    end

    // saved targets
    // a later redirect of the same kind replaces the earlier one
    always_ff @(posedge clk) begin
        if (stall && exc_valid) begin
            exc_hold <= exc_target;
        end
        if (stall && branch_valid) begin
            branch_hold <= branch_target;
        end
    end

    // next pc by priority
    // exception first, live before saved
    // a saved exception still beats a newer branch
    always_comb begin
        if (exc_valid) begin
            pc_next = exc_target;
        end else if (exc_saved) begin
            pc_next = exc_hold;
        end else if (branch_valid) begin
            pc_next = branch_target;
        end else if (branch_saved) begin
            pc_next = branch_hold;
        end else begin
            pc_next = pc_seq;
        end
    end

    // pc moves when consumed
    // a redirect also moves it at once unless it is held on the bus
    assign pc_load = fire | (redirect & ~stall);

    // pc register
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
        end else if (pc_load) begin
            pc <= pc_next;
        end
    end

endmodule

// File: flist.f
common/bus_pkg.sv
common/fetch_pkg.sv
source/fetch_hazard.sv
fetch/pc_select.sv
fetch/fetch_buffer.sv
fetch/fetch_frontend.sv
testbench/fetch_properties.sv
testbench/tb_fetch_frontend.sv

// File: source/fetch_hazard.sv
`timescale 1ns/1ns

module fetch_hazard #(
    parameter int unsigned credits = 4
) (
    input  logic           clk,
    input  logic           reset,
    input  bus_pkg::addr_t pc,
    input  logic           ireq_addr_ok,
    input  logic           iresp_data_ok,
    input  logic           credit_return,
    input  logic           exc_valid,
    input  logic           branch_valid,
    output logic           ireq_valid,
    output logic           stall,
    output logic           fire,
    output logic           discard,
    output logic           addr_error,
    output logic           line_ok
);

    fetch_pkg::fetch_state_t state;
    fetch_pkg::fetch_state_t state_next;
    fetch_pkg::credit_t      credit_cnt;

    logic running;
    logic aligned;
    logic have_credit;
    logic can_fetch;
    logic redirect;
    logic redirect_held;
    logic stale;
    logic accept;
    logic resp_drop;

    assign redirect    = exc_valid | branch_valid;
    assign aligned     = (pc[1:0] == 2'b00);
    assign have_credit = (credit_cnt != '0);

    // first cycle after reset stays idle
    assign can_fetch = running & (state == fetch_pkg::FETCH_REQ) & have_credit;

    // bus request only for a word-aligned pc
    assign ireq_valid = can_fetch & aligned;
    assign accept     = ireq_valid & ireq_addr_ok;

    // misaligned pc turns into an error packet
    // skipped when a redirect replaces the pc in the same cycle
    assign addr_error = can_fetch & ~aligned & ~redirect;

    assign fire = accept | addr_error;

    // pc held on the bus until the address is taken
    assign stall = ireq_valid & ~ireq_addr_ok;

    // redirect seen while the pc was held
    // the request that finally goes out is already stale
    always_ff @(posedge clk) begin
        if (reset) begin
            redirect_held <= 1'b0;
        end else if (stall && redirect) begin
            redirect_held <= 1'b1;
        end else if (!stall) begin
            redirect_held <= 1'b0;
        end
    end

    assign stale = redirect | redirect_held;

    // response for the outstanding request
    assign line_ok = iresp_data_ok & (state != fetch_pkg::FETCH_REQ);

    // dropped while draining, or when a redirect meets the response
    assign resp_drop = line_ok & ((state == fetch_pkg::FETCH_DRAIN) | redirect);

    // stale request at acceptance, or stale response
    assign discard = resp_drop | (accept & stale);

    // fetch FSM
    always_comb begin
        state_next = state;
        case (state)
            fetch_pkg::FETCH_REQ: begin
                if (accept) begin
                    state_next = stale ? fetch_pkg::FETCH_DRAIN : fetch_pkg::FETCH_WAIT;
                end
            end
            fetch_pkg::FETCH_WAIT: begin
                if (iresp_data_ok) begin
                    state_next = fetch_pkg::FETCH_REQ;
                end else if (redirect) begin
                    state_next = fetch_pkg::FETCH_DRAIN;
                end
            end
            fetch_pkg::FETCH_DRAIN: begin
                if (iresp_data_ok) begin
                    state_next = fetch_pkg::FETCH_REQ;
                end
            end
            default: begin
                state_next = fetch_pkg::FETCH_REQ;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= fetch_pkg::FETCH_REQ;
            running <= 1'b0;
        end else begin
            state   <= state_next;
            running <= 1'b1;
        end
    end

    // credits
    // one spent per consumed pc
    // one back per consumer pulse and per dropped response
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= fetch_pkg::credit_t'(credits);
        end else begin
            credit_cnt <= credit_cnt
                        + fetch_pkg::credit_t'(credit_return)
                        + fetch_pkg::credit_t'(resp_drop)
                        - fetch_pkg::credit_t'(fire);
        end
    end

endmodule

// File: testbench/fetch_properties.sv
`timescale 1ns/1ns

module fetch_properties #(
    parameter int unsigned credits = 4
) (
    input logic           clk,
    input logic           reset,
    input logic           ireq_valid,
    input bus_pkg::addr_t ireq_addr,
    input logic           ireq_addr_ok,
    input logic           iresp_data_ok,
    input fetch_pkg::credit_t credit_cnt
);

    // one request in flight between acceptance and its response
    logic outstanding;

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (ireq_valid && ireq_addr_ok) begin
            outstanding <= 1'b1;
        end else if (iresp_data_ok) begin
            outstanding <= 1'b0;
        end
    end

    // credit counter stays within the configured count
    credit_bound: assert property (@(posedge clk) disable iff (reset)
        credit_cnt <= credits)
        else $error("credit count above its limit");

    // no second request while one is outstanding
    single_request: assert property (@(posedge clk) disable iff (reset)
        outstanding |-> !ireq_valid)
        else $error("request raised while another is outstanding");

    // address held until the bus takes it
    addr_stable: assert property (@(posedge clk) disable iff (reset)
        ireq_valid && !ireq_addr_ok |=> ireq_valid && $stable(ireq_addr))
        else $error("request address changed before acceptance");

endmodule

bind fetch_frontend fetch_properties #(
    .credits (credits)
) i_fetch_properties (
    .clk           (clk),
    .reset         (reset),
    .ireq_valid    (ireq_valid),
    .ireq_addr     (ireq_addr),
    .ireq_addr_ok  (ireq_addr_ok),
    .iresp_data_ok (iresp_data_ok),
    .credit_cnt    (i_fetch_hazard.credit_cnt)
);

// File: testbench/tb_fetch_frontend.sv
`timescale 1ns/1ns

module tb_fetch_frontend;

    localparam int unsigned credit_count = 4;
    localparam logic [31:0] start_pc     = 32'hbfc0_0000;
    localparam int          num_rows     = 7;

    logic clk, reset, ireq_valid, ireq_addr_ok, iresp_data_ok;
    logic exc_valid, branch_valid, pkt_valid, pkt_slot1_valid, pkt_addr_error, credit_return;
    logic [31:0] ireq_addr, exc_target, branch_target, pkt_pc, pkt_instr0, pkt_instr1;
    logic [63:0] iresp_data;

    // stimulus table with one entry per test
    // kind 0 none, 1 branch, 2 exception, 3 both at once, 4 exception then branch
    int          row_lat [num_rows], row_cyc [num_rows], row_kind [num_rows];
    int          row_cdly [num_rows], row_hold [num_rows], row_min [num_rows];
    int          row_nexp [num_rows], row_len [num_rows];
    logic [31:0] row_target [num_rows];
    logic [31:0] row_exp [num_rows][3];

    // packets as the consumer saw them
    logic [31:0] pkt_pc_q [$];
    logic [31:0] pkt_instr0_q [$];
    logic [31:0] pkt_instr1_q [$];
    logic        pkt_slot1_q [$];
    logic        pkt_err_q [$];
    int          pkt_cyc_q [$], credit_due_q [$];
    int          cur, cyc, held, errors, failed_tests, busy, resp_cnt, k;
    int          cycle_count = 0;
    int          cycle_limit = 1000000;
    integer      seed = 32'hd997;
    logic [31:0] resp_addr;

    fetch_frontend #(.credits(credit_count), .reset_vector(start_pc)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // word at address A of the memory model
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    task automatic add_row(input int idx, lat, rc, kind, input logic [31:0] t,
                           input int cdly, hold, min_pkts, nexp, len,
                           input logic [31:0] e0, e1, e2);
        row_lat[idx]    = lat;
        row_cyc[idx]    = rc;
        row_kind[idx]   = kind;
        row_target[idx] = t;
        row_cdly[idx]   = cdly;
        row_hold[idx]   = hold;
        row_min[idx]    = min_pkts;
        row_nexp[idx]   = nexp;
        row_len[idx]    = len;
        row_exp[idx][0] = e0;
        row_exp[idx][1] = e1;
        row_exp[idx][2] = e2;
    endtask

    task automatic compare(input string name, input logic [31:0] got, exp);
        assert (got === exp) else begin
            $display("MISMATCH %s got %h expected %h in test %0d", name, got, exp, cur);
            errors++;
        end
    endtask

    // payload follows from the expected pc alone
    task automatic check_packet(input int idx, input logic [31:0] pc);
        logic misaligned;
        misaligned = (pc[1:0] != 2'b00);
        compare("pkt_pc", pkt_pc_q[idx], pc);
        compare("pkt_addr_error", pkt_err_q[idx], misaligned);
        compare("pkt_slot1_valid", pkt_slot1_q[idx], !misaligned && !pc[2]);
        compare("pkt_instr0", pkt_instr0_q[idx], misaligned ? 32'h0 : mem_word(pc));
        compare("pkt_instr1", pkt_instr1_q[idx],
                (misaligned || pc[2]) ? 32'h0 : mem_word(pc + 4));
    endtask

    task automatic run_cycle();
        logic        acc;
        logic        resp_seen;
        logic [31:0] acc_addr;
        @(negedge clk);
        assert (!(ireq_valid && ireq_addr[1:0] != 2'b00)) else begin
            $display("bus request for misaligned address %h in test %0d", ireq_addr, cur);
            errors++;
        end
        acc       = ireq_valid & ireq_addr_ok;
        acc_addr  = ireq_addr;
        resp_seen = iresp_data_ok;
        if (pkt_valid) begin
            pkt_pc_q.push_back(pkt_pc);
            pkt_instr0_q.push_back(pkt_instr0);
            pkt_instr1_q.push_back(pkt_instr1);
            pkt_slot1_q.push_back(pkt_slot1_valid);
            pkt_err_q.push_back(pkt_addr_error);
            pkt_cyc_q.push_back(cyc);
            credit_due_q.push_back(cyc + row_cdly[cur]);
            held--;
            assert (held >= 0) else begin
                $display("packet arrived with no credit left in test %0d", cur);
                errors++;
            end
        end
        @(posedge clk);
        #2;
        cyc++;
        // memory model with one response per accepted request
        if (resp_seen) begin
            iresp_data_ok = 1'b0;
            busy = 0;
        end
        if (acc) begin
            busy      = 1;
            resp_cnt  = row_lat[cur] + ($random(seed) & 1);
            resp_addr = {acc_addr[31:3], 3'b000};
        end
        if (busy != 0 && !iresp_data_ok) begin
            if (resp_cnt <= 1) begin
                iresp_data_ok = 1'b1;
                iresp_data    = {mem_word(resp_addr + 4), mem_word(resp_addr)};
            end else begin
                resp_cnt--;
            end
        end
        // bus refuses addresses around the redirect when the row asks for it
        ireq_addr_ok = !(row_hold[cur] != 0 && cyc >= row_cyc[cur] - 4
                         && cyc <= row_cyc[cur] + 3);
        exc_valid     = (row_kind[cur] >= 2) && (cyc == row_cyc[cur]);
        branch_valid  = (row_kind[cur] == 1 || row_kind[cur] == 3) && (cyc == row_cyc[cur])
                     || (row_kind[cur] == 4) && (cyc == row_cyc[cur] + 1);
        exc_target    = row_target[cur];
        branch_target = (row_kind[cur] >= 3) ? row_target[cur] + 32'h1000 : row_target[cur];
        credit_return = 1'b0;
        if (credit_due_q.size() > 0 && credit_due_q[0] <= cyc) begin
            void'(credit_due_q.pop_front());
            credit_return = 1'b1;
            held++;
        end
    endtask

    function automatic int post_count();
        int n;
        n = 0;
        foreach (pkt_cyc_q[i]) begin
            if (pkt_cyc_q[i] > row_cyc[cur]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic reset_dut();
        @(posedge clk);
        #2;
        reset = 1'b1;
        {exc_valid, branch_valid, credit_return, iresp_data_ok} = '0;
        ireq_addr_ok = 1'b1;
        busy = 0;
        held = credit_count;
        pkt_pc_q.delete();
        pkt_instr0_q.delete();
        pkt_instr1_q.delete();
        pkt_slot1_q.delete();
        pkt_err_q.delete();
        pkt_cyc_q.delete();
        credit_due_q.delete();
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        cyc = 0;
    endtask

    // before the redirect sequential from reset
    // after it the listed pcs and then sequential lines
    task automatic check_row();
        int          n_pre;
        int          n_post;
        logic [31:0] exp;
        n_pre  = 0;
        n_post = 0;
        exp    = '0;
        foreach (pkt_pc_q[i]) begin
            if (pkt_cyc_q[i] <= row_cyc[cur]) begin
                check_packet(i, start_pc + 8 * n_pre);
                n_pre++;
            end else begin
                exp = (n_post < row_nexp[cur]) ? row_exp[cur][n_post]
                                               : {exp[31:3], 3'b000} + fetch_pkg::LINE_BYTES;
                check_packet(i, exp);
                n_post++;
            end
        end
    endtask

    initial begin : watchdog
        @(posedge clk);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, the tests did not finish within %0d cycles", cycle_limit);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int errors_before;
        reset = 1'b1;
        {ireq_addr_ok, iresp_data_ok, exc_valid, branch_valid, credit_return} = '0;
        {iresp_data, exc_target, branch_target} = '0;
        errors = 0;
        failed_tests = 0;
        cur = 0;
        add_row(0, 1, 1000, 0, 32'h0,         3, 0, 8,  0, 40, 32'h0, 32'h0, 32'h0);
        add_row(1, 2, 12, 1, 32'h8000_0104,   3, 0, 4,  3, 45,
                32'h8000_0104, 32'h8000_0108, 32'h8000_0110);
        add_row(2, 4, 15, 1, 32'h8000_2000,   3, 0, 4,  3, 55,
                32'h8000_2000, 32'h8000_2008, 32'h8000_2010);
        add_row(3, 2, 13, 3, 32'h8000_0300,   3, 0, 3,  2, 45, 32'h8000_0300, 32'h8000_0308, 0);
        add_row(4, 1, 14, 4, 32'h8000_0400,   3, 1, 3,  2, 50, 32'h8000_0400, 32'h8000_0408, 0);
        add_row(5, 1, 12, 2, 32'h8000_0502,   3, 0, 4,  3, 45,
                32'h8000_0502, 32'h8000_0508, 32'h8000_0510);
        add_row(6, 1, 1000, 0, 32'h0,        20, 0, 10, 0, 90, 32'h0, 32'h0, 32'h0);
        cycle_limit = 0;
        for (k = 0; k < num_rows; k++) begin
            cycle_limit += row_len[k] * 4;
        end
        for (cur = 0; cur < num_rows; cur++) begin
            errors_before = errors;
            reset_dut();
            while (!((row_kind[cur] == 0 || cyc > row_cyc[cur] + 1)
                     && post_count() >= row_nexp[cur] && pkt_pc_q.size() >= row_min[cur])) begin
                run_cycle();
            end
            check_row();
            if (errors != errors_before) begin
                failed_tests++;
            end
            $display("test %0d: %0d packets, %s", cur, pkt_pc_q.size(),
                     (errors == errors_before) ? "ok" : "FAILED");
        end
        $display("tests %0d, failed tests %0d, failed checks %0d", num_rows, failed_tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
